// File: include/axis_defines.svh
// ========================================
// stream geometry and FIFO sizing
// the narrow side carries a single byte lane
// FIFO depth must be a power of two
// ========================================

`ifndef AXIS_DEFINES_SVH
`define AXIS_DEFINES_SVH

// bits per byte lane
`define AXIS_BYTE_W 8
// lanes on the byte side and on the word side
`define AXIS_NARROW_LANES 1
`define AXIS_WIDE_LANES 4
// word entries held by the FIFO
`define AXIS_FIFO_DEPTH 8

`endif

// File: verilog/axis_pkg.sv
// ========================================
// stream payload types, sized from the
// macros in axis_defines.svh
// byte 0 sits in the low bits of a word
// ========================================

`include "axis_defines.svh"

package axis_pkg;

    // one byte lane
    typedef logic [`AXIS_BYTE_W-1:0] byte_t;

    // one wide word
    typedef logic [`AXIS_WIDE_LANES*`AXIS_BYTE_W-1:0] word_t;

    // bit n qualifies byte n of a word
    typedef logic [`AXIS_WIDE_LANES-1:0] wkeep_t;

    // frame sideband flag
    typedef logic user_t;

endpackage

// File: verilog/axis_adapter.sv
// ========================================
// stream width adapter, upsize or downsize
// lane counts must differ and divide evenly
// downsize drops null lanes, so a frame
// must end on a kept byte to keep its tlast
// ========================================

`include "axis_defines.svh"

module axis_adapter import axis_pkg::*; #(
    parameter int S_KEEP_WIDTH = 1,
    parameter int M_KEEP_WIDTH = 4,
    localparam int S_DATA_W = S_KEEP_WIDTH * `AXIS_BYTE_W,
    localparam int M_DATA_W = M_KEEP_WIDTH * `AXIS_BYTE_W
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic [S_DATA_W-1:0]     s_tdata,
    input  logic [S_KEEP_WIDTH-1:0] s_tkeep,
    input  logic                    s_tvalid,
    output logic                    s_tready,
    input  logic                    s_tlast,
    input  user_t                   s_tuser,

    output logic [M_DATA_W-1:0]     m_tdata,
    output logic [M_KEEP_WIDTH-1:0] m_tkeep,
    output logic                    m_tvalid,
    input  logic                    m_tready,
    output logic                    m_tlast,
    output user_t                   m_tuser
);

    if (M_KEEP_WIDTH > S_KEEP_WIDTH) begin : g_upsize
        localparam int SEG_COUNT = M_KEEP_WIDTH / S_KEEP_WIDTH;
        localparam int SEG_W = $clog2(SEG_COUNT);

        logic [SEG_W-1:0]        seg;

        // skid entry for a beat that arrives while the word is stalled
        logic [S_DATA_W-1:0]     skid_data;
        logic [S_KEEP_WIDTH-1:0] skid_keep;
        logic                    skid_valid;
        logic                    skid_last;
        user_t                   skid_user;

        logic [M_DATA_W-1:0]     word_data;
        logic [M_KEEP_WIDTH-1:0] word_keep;
        logic                    word_valid;
        logic                    word_last;
        user_t                   word_user;

        // next beat to pack, skid entry first
        logic [S_DATA_W-1:0]     in_data;
        logic [S_KEEP_WIDTH-1:0] in_keep;
        logic                    in_valid;
        logic                    in_last;
        user_t                   in_user;
        logic                    in_close;

        assign in_data  = skid_valid ? skid_data : s_tdata;
        assign in_keep  = skid_valid ? skid_keep : s_tkeep;
        assign in_last  = skid_valid ? skid_last : s_tlast;
        assign in_user  = skid_valid ? skid_user : s_tuser;
        assign in_valid = skid_valid || s_tvalid;
        assign in_close = in_last || (seg == SEG_W'(SEG_COUNT - 1));

        assign s_tready = !skid_valid;

        assign m_tdata  = word_data;
        assign m_tkeep  = word_keep;
        assign m_tvalid = word_valid;
        assign m_tlast  = word_last;
        assign m_tuser  = word_user;

        always_ff @(posedge clk) begin
            word_valid <= word_valid && !m_tready;

            if (!word_valid || m_tready) begin
                if (in_valid) begin
                    word_data[seg*S_DATA_W +: S_DATA_W] <= in_data;
                    // first lane clears the keep bits of the lanes above
                    if (seg == '0) begin
                        word_keep <= M_KEEP_WIDTH'(in_keep);
                    end else begin
                        word_keep[seg*S_KEEP_WIDTH +: S_KEEP_WIDTH] <= in_keep;
                    end
                    word_last  <= in_last;
                    word_user  <= in_user;
                    skid_valid <= 1'b0;

                    if (in_close) begin
                        seg        <= '0;
                        word_valid <= 1'b1;
                    end else begin
                        seg <= seg + 1'b1;
                    end
                end
            end else if (s_tvalid && s_tready) begin
                skid_data  <= s_tdata;
                skid_keep  <= s_tkeep;
                skid_last  <= s_tlast;
                skid_user  <= s_tuser;
                skid_valid <= 1'b1;
            end

            if (rst) begin
                seg        <= '0;
                skid_valid <= 1'b0;
                word_valid <= 1'b0;
            end
        end
    end else begin : g_downsize
        localparam int SEG_COUNT = S_KEEP_WIDTH / M_KEEP_WIDTH;
        localparam int SEG_DATA_W = S_DATA_W / SEG_COUNT;
        localparam int SEG_KEEP_W = S_KEEP_WIDTH / SEG_COUNT;

        // input word with its kept segments packed toward segment 0
        logic [S_DATA_W-1:0]     comp_data;
        logic [S_KEEP_WIDTH-1:0] comp_keep;

        // shift register of segments still to send
        logic [S_DATA_W-1:0]     shift_data;
        logic [S_KEEP_WIDTH-1:0] shift_keep;
        logic                    shift_valid;
        logic                    shift_last;
        user_t                   shift_user;

        logic [M_DATA_W-1:0]     out_data;
        logic [M_KEEP_WIDTH-1:0] out_keep;
        logic                    out_valid;
        logic                    out_last;
        user_t                   out_user;

        always_comb begin
            int fill;
            fill      = 0;
            comp_data = '0;
            comp_keep = '0;
            for (int i = 0; i < SEG_COUNT; i++) begin
                if (s_tkeep[i*SEG_KEEP_W +: SEG_KEEP_W] != '0) begin
                    comp_data[fill*SEG_DATA_W +: SEG_DATA_W] = s_tdata[i*SEG_DATA_W +: SEG_DATA_W];
                    comp_keep[fill*SEG_KEEP_W +: SEG_KEEP_W] = s_tkeep[i*SEG_KEEP_W +: SEG_KEEP_W];
                    fill = fill + 1;
                end
            end
        end

        assign s_tready = !shift_valid;

        assign m_tdata  = out_data;
        assign m_tkeep  = out_keep;
        assign m_tvalid = out_valid;
        assign m_tlast  = out_last;
        assign m_tuser  = out_user;

        always_ff @(posedge clk) begin
            out_valid <= out_valid && !m_tready;

            if (!out_valid || m_tready) begin
                if (shift_valid) begin
                    out_data   <= shift_data[SEG_DATA_W-1:0];
                    out_keep   <= shift_keep[SEG_KEEP_W-1:0];
                    out_user   <= shift_user;
                    out_valid  <= 1'b1;
                    out_last   <= 1'b0;
                    shift_data <= shift_data >> SEG_DATA_W;
                    shift_keep <= shift_keep >> SEG_KEEP_W;
                    if ((shift_keep >> SEG_KEEP_W) == '0) begin
                        shift_valid <= 1'b0;
                        out_last    <= shift_last;
                    end
                end else if (s_tvalid && comp_keep != '0) begin
                    // send segment 0 now, keep the rest
                    out_data    <= comp_data[SEG_DATA_W-1:0];
                    out_keep    <= comp_keep[SEG_KEEP_W-1:0];
                    out_user    <= s_tuser;
                    out_valid   <= 1'b1;
                    out_last    <= s_tlast && ((comp_keep >> SEG_KEEP_W) == '0);
                    shift_data  <= comp_data >> SEG_DATA_W;
                    shift_keep  <= comp_keep >> SEG_KEEP_W;
                    shift_last  <= s_tlast;
                    shift_user  <= s_tuser;
                    shift_valid <= (comp_keep >> SEG_KEEP_W) != '0;
                end
            end else if (s_tvalid && s_tready && comp_keep != '0) begin
                shift_data  <= comp_data;
                shift_keep  <= comp_keep;
                shift_last  <= s_tlast;
                shift_user  <= s_tuser;
                shift_valid <= 1'b1;
            end

            if (rst) begin
                shift_valid <= 1'b0;
                out_valid   <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/axis_fifo.sv
// ========================================
// synchronous FIFO of stream words
// output is read straight from the array
// no write is taken while full
// ========================================

`include "axis_defines.svh"

module axis_fifo import axis_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  word_t  s_tdata,
    input  wkeep_t s_tkeep,
    input  logic   s_tvalid,
    output logic   s_tready,
    input  logic   s_tlast,
    input  user_t  s_tuser,

    output word_t  m_tdata,
    output wkeep_t m_tkeep,
    output logic   m_tvalid,
    input  logic   m_tready,
    output logic   m_tlast,
    output user_t  m_tuser
);

    localparam int DEPTH = `AXIS_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);

    word_t       mem_data [DEPTH];
    wkeep_t      mem_keep [DEPTH];
    logic        mem_last [DEPTH];
    user_t       mem_user [DEPTH];

    // extra top bit tells a full FIFO from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        wr_en;
    logic        rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_en = s_tvalid && !full;
    assign rd_en = m_tready && !empty;

    assign s_tready = !full;
    assign m_tvalid = !empty;

    assign m_tdata = mem_data[rd_ptr[AW-1:0]];
    assign m_tkeep = mem_keep[rd_ptr[AW-1:0]];
    assign m_tlast = mem_last[rd_ptr[AW-1:0]];
    assign m_tuser = mem_user[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[AW-1:0]] <= s_tdata;
            mem_keep[wr_ptr[AW-1:0]] <= s_tkeep;
            mem_last[wr_ptr[AW-1:0]] <= s_tlast;
            mem_user[wr_ptr[AW-1:0]] <= s_tuser;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: verilog/axis_width_bridge.sv
// ========================================
// byte stream in, word FIFO, byte stream out
// null bytes on the input are dropped
// at the output, which has no tkeep
// ========================================

`include "axis_defines.svh"

module axis_width_bridge import axis_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  byte_t s_axis_tdata,
    input  logic  s_axis_tkeep,
    input  logic  s_axis_tvalid,
    output logic  s_axis_tready,
    input  logic  s_axis_tlast,
    input  user_t s_axis_tuser,

    output byte_t m_axis_tdata,
    output logic  m_axis_tvalid,
    input  logic  m_axis_tready,
    output logic  m_axis_tlast,
    output user_t m_axis_tuser
);

    // upsizer to FIFO
    word_t  up_tdata;
    wkeep_t up_tkeep;
    logic   up_tvalid;
    logic   up_tready;
    logic   up_tlast;
    user_t  up_tuser;

    // FIFO to downsizer
    word_t  fifo_tdata;
    wkeep_t fifo_tkeep;
    logic   fifo_tvalid;
    logic   fifo_tready;
    logic   fifo_tlast;
    user_t  fifo_tuser;

    axis_adapter #(
        .S_KEEP_WIDTH (`AXIS_NARROW_LANES),
        .M_KEEP_WIDTH (`AXIS_WIDE_LANES)
    ) up_adapter_i (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (s_axis_tdata),
        .s_tkeep  (s_axis_tkeep),
        .s_tvalid (s_axis_tvalid),
        .s_tready (s_axis_tready),
        .s_tlast  (s_axis_tlast),
        .s_tuser  (s_axis_tuser),
        .m_tdata  (up_tdata),
        .m_tkeep  (up_tkeep),
        .m_tvalid (up_tvalid),
        .m_tready (up_tready),
        .m_tlast  (up_tlast),
        .m_tuser  (up_tuser)
    );

    axis_fifo word_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (up_tdata),
        .s_tkeep  (up_tkeep),
        .s_tvalid (up_tvalid),
        .s_tready (up_tready),
        .s_tlast  (up_tlast),
        .s_tuser  (up_tuser),
        .m_tdata  (fifo_tdata),
        .m_tkeep  (fifo_tkeep),
        .m_tvalid (fifo_tvalid),
        .m_tready (fifo_tready),
        .m_tlast  (fifo_tlast),
        .m_tuser  (fifo_tuser)
    );

    // output keep is always set, so it stays inside the bridge
    axis_adapter #(
        .S_KEEP_WIDTH (`AXIS_WIDE_LANES),
        .M_KEEP_WIDTH (`AXIS_NARROW_LANES)
    ) down_adapter_i (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (fifo_tdata),
        .s_tkeep  (fifo_tkeep),
        .s_tvalid (fifo_tvalid),
        .s_tready (fifo_tready),
        .s_tlast  (fifo_tlast),
        .s_tuser  (fifo_tuser),
        .m_tdata  (m_axis_tdata),
        .m_tkeep  (),
        .m_tvalid (m_axis_tvalid),
        .m_tready (m_axis_tready),
        .m_tlast  (m_axis_tlast),
        .m_tuser  (m_axis_tuser)
    );

endmodule

// File: dv/axis_bridge_props.sv
// ========================================
// handshake checks on the bridge ports
// bound into every axis_width_bridge
// ========================================

module axis_bridge_props import axis_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  s_axis_tready,
    input byte_t m_axis_tdata,
    input logic  m_axis_tvalid,
    input logic  m_axis_tready,
    input logic  m_axis_tlast,
    input user_t m_axis_tuser
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled output beat holds until taken
    a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
            && $stable(m_axis_tlast) && $stable(m_axis_tuser))
        else $error("m_axis beat changed while stalled");

    a_reset_valid: assert property (@(posedge clk) rst |=> !m_axis_tvalid)
        else $error("m_axis_tvalid high after reset");

    a_reset_ready: assert property (@(posedge clk) rst |=> s_axis_tready)
        else $error("s_axis_tready low after reset");

endmodule

bind axis_width_bridge axis_bridge_props props_i (.*);

// File: dv/axis_bridge_tb.sv
// ========================================
// directed tests for the byte width bridge
// inputs change 1 ns after the rising edge
// outputs are sampled on the falling edge
// the first mismatch ends the run
// ========================================

`include "axis_defines.svh"

module axis_bridge_tb import axis_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20000;

    logic  clk = 1'b0;
    logic  rst;
    byte_t s_axis_tdata;
    logic  s_axis_tkeep;
    logic  s_axis_tvalid;
    logic  s_axis_tready;
    logic  s_axis_tlast;
    user_t s_axis_tuser;
    byte_t m_axis_tdata;
    logic  m_axis_tvalid;
    logic  m_axis_tready = 1'b1;
    logic  m_axis_tlast;
    user_t m_axis_tuser;

    // 0 always ready, 1 random stalls, 2 held low
    int          ready_mode = 0;
    int          cycle_count = 0;
    logic [31:0] data_lfsr = 32'h99db;
    logic [31:0] stall_lfsr = 32'h99db;

    // frame being sent, and the bytes the output should show
    byte_t tx_data[$];
    user_t tx_user[$];
    byte_t exp_data[$];
    user_t exp_user[$];
    bit    exp_last[$];

    axis_width_bridge dut_i (.*);

    always #50 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            v = {v[30:0], data_lfsr[0]};
        end
    endtask

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_user(input string name, input user_t got, input user_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_last(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin : drive_ready
        logic rdy;
        rdy = 1'b1;
        if (ready_mode == 1) begin
            stall_lfsr = lfsr_step(stall_lfsr);
            rdy = stall_lfsr[0];
        end else if (ready_mode == 2) begin
            rdy = 1'b0;
        end
        #1;
        m_axis_tready = rdy;
    end

    always @(negedge clk) begin : check_output
        byte_t d;
        user_t u;
        bit    l;
        if (m_axis_tvalid === 1'b1 && m_axis_tready) begin
            if (exp_data.size() == 0) begin
                $display("output byte 0x%02h arrived with none expected", m_axis_tdata);
                abort_run();
            end else begin
                d = exp_data.pop_front();
                u = exp_user.pop_front();
                l = exp_last.pop_front();
                compare_byte("m_axis_tdata", m_axis_tdata, d);
                compare_user("m_axis_tuser", m_axis_tuser, u);
                compare_last("m_axis_tlast", m_axis_tlast, l);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d bytes still expected",
                     cycle_count, exp_data.size());
            abort_run();
        end
    end

    task automatic build_frame(input int len, input bit random_user);
        logic [31:0] v;
        int          grp_end;
        tx_data.delete();
        tx_user.delete();
        for (int i = 0; i < len; i++) begin
            draw_bits(8, v);
            tx_data.push_back(v[7:0]);
            v = '0;
            if (random_user) begin
                draw_bits(1, v);
            end
            tx_user.push_back(v[0]);
        end
        // each byte takes the user of the last byte in its group of four
        for (int i = 0; i < len; i++) begin
            grp_end = (i / 4) * 4 + 3;
            if (grp_end > len - 1) begin
                grp_end = len - 1;
            end
            exp_data.push_back(tx_data[i]);
            exp_user.push_back(tx_user[grp_end]);
            exp_last.push_back(i == len - 1);
        end
    endtask

    // stall_limit of 0 means send until the frame is done
    task automatic send_bytes(input int first, input bit gaps, input int stall_limit,
                              output int next_idx);
        int          low_run;
        bit          fresh;
        logic [31:0] v;
        next_idx = first;
        low_run  = 0;
        fresh    = 1'b1;
        while (next_idx < tx_data.size() && (stall_limit == 0 || low_run < stall_limit)) begin
            v = '0;
            if (fresh && gaps) begin
                draw_bits(1, v);
            end
            if (v[0]) begin
                s_axis_tvalid = 1'b0;
            end else begin
                s_axis_tdata  = tx_data[next_idx];
                s_axis_tuser  = tx_user[next_idx];
                s_axis_tlast  = (next_idx == tx_data.size() - 1);
                s_axis_tvalid = 1'b1;
            end
            @(negedge clk);
            if (s_axis_tvalid && s_axis_tready) begin
                next_idx++;
                low_run = 0;
                fresh   = 1'b1;
            end else if (s_axis_tvalid) begin
                low_run++;
                fresh = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        // an unaccepted byte stays offered
        if (next_idx >= tx_data.size()) begin
            s_axis_tvalid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic test_frame_lengths();
        int n;
        for (int len = 1; len <= 9; len++) begin
            build_frame(len, 1'b0);
            send_bytes(0, 1'b0, 0, n);
        end
        wait_drain();
    endtask

    task automatic test_output_stalls();
        logic [31:0] v;
        int          n;
        ready_mode = 1;
        for (int f = 0; f < 6; f++) begin
            draw_bits(5, v);
            build_frame(int'(v[4:0]) + 1, 1'b0);
            send_bytes(0, 1'b0, 0, n);
        end
        wait_drain();
        ready_mode = 0;
    endtask

    task automatic test_input_gaps();
        logic [31:0] v;
        int          n;
        for (int f = 0; f < 6; f++) begin
            draw_bits(4, v);
            build_frame(int'(v[3:0]) + 1, 1'b0);
            send_bytes(0, 1'b1, 0, n);
        end
        wait_drain();
    endtask

    task automatic test_user_flags();
        int lens[5] = '{3, 4, 7, 8, 11};
        int n;
        foreach (lens[i]) begin
            build_frame(lens[i], 1'b1);
            send_bytes(0, 1'b0, 0, n);
        end
        wait_drain();
    endtask

    task automatic test_fill_drain();
        int n;
        ready_mode = 2;
        build_frame(64, 1'b0);
        send_bytes(0, 1'b0, 10, n);
        if (n < `AXIS_FIFO_DEPTH * 4) begin
            $display("input stalled after only %0d bytes with the output held", n);
            abort_run();
        end
        ready_mode = 0;
        send_bytes(n, 1'b0, 0, n);
        wait_drain();
    endtask

    initial begin
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tkeep  = 1'b1;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        s_axis_tuser  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_frame_lengths();
        test_output_stalls();
        test_input_gaps();
        test_user_flags();
        test_fill_drain();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
verilog/axis_pkg.sv
verilog/axis_adapter.sv
verilog/axis_fifo.sv
verilog/axis_width_bridge.sv
dv/axis_bridge_props.sv
dv/axis_bridge_tb.sv

// File: run.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module axis_bridge_tb \
    -o axis_bridge_sim \
    && ./obj_dir/axis_bridge_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -qx "ALL CHECKS PASSED" sim.log || { echo "simulation did not pass"; exit 1; }
echo "simulation passed"
